// File: logic/com_pkg.sv
`default_nettype none

package com_pkg;

    localparam int ADDR_W = 12;  // RAM address and frame length
    localparam int BYTE_W = 8;

    // packet type codes
    localparam logic [3:0] BAG_INIT   = 4'b0000;
    localparam logic [3:0] BAG_ACK    = 4'b0001;
    localparam logic [3:0] BAG_NAK    = 4'b0010;
    localparam logic [3:0] BAG_STL    = 4'b0011;
    localparam logic [3:0] BAG_DIDX   = 4'b0101;
    localparam logic [3:0] BAG_DPARAM = 4'b0110;
    localparam logic [3:0] BAG_DDIDX  = 4'b0111;
    localparam logic [3:0] BAG_DLINK  = 4'b1000;
    localparam logic [3:0] BAG_DTYPE  = 4'b1001;
    localparam logic [3:0] BAG_DTEMP  = 4'b1010;
    localparam logic [3:0] BAG_DATA0  = 4'b1101;
    localparam logic [3:0] BAG_DATA1  = 4'b1110;
    localparam logic [3:0] BAG_ERROR  = 4'b1111;

    // frame header seen as type/length or as the two channel bytes
    typedef union packed {
        struct packed {
            logic [3:0]        btype;
            logic [ADDR_W-1:0] dlen;
        } f;
        struct packed {
            logic [BYTE_W-1:0] hi;  // goes out first
            logic [BYTE_W-1:0] lo;
        } b;
    } com_hdr_u;

endpackage

`default_nettype wire

// File: logic/packet_ram.sv
`timescale 1ns/10ps
`default_nettype none

module packet_ram import com_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [BYTE_W-1:0] wdata,
    output logic [BYTE_W-1:0] rdata
);

    logic [BYTE_W-1:0] mem [0:(1 << ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr];  // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: logic/ram_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module ram_arbiter import com_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_req,
    input  logic              rx_we,
    input  logic [ADDR_W-1:0] rx_addr,
    input  logic [BYTE_W-1:0] rx_wdata,
    input  logic              tx_req,
    input  logic [ADDR_W-1:0] tx_addr,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [BYTE_W-1:0] host_wdata,
    input  logic [BYTE_W-1:0] mem_rdata,
    output logic              rx_gnt,
    output logic              tx_gnt,
    output logic [BYTE_W-1:0] tx_rdata,
    output logic              host_gnt,
    output logic [BYTE_W-1:0] host_rdata,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [BYTE_W-1:0] mem_wdata
);

    logic tx_own, host_own;  // owner of the read issued last cycle

    // deframer never waits
    assign rx_gnt   = rx_req;
    assign tx_gnt   = tx_req && !rx_req;
    assign host_gnt = host_req && !rx_req && !tx_req;

    assign mem_we    = rx_req ? rx_we : (host_gnt && host_we);
    assign mem_addr  = rx_req ? rx_addr : (tx_req ? tx_addr : host_addr);
    assign mem_wdata = rx_req ? rx_wdata : host_wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_own   <= 1'b0;
            host_own <= 1'b0;
        end else begin
            tx_own   <= tx_gnt;
            host_own <= host_gnt && !host_we;
        end
    end

    assign tx_rdata   = tx_own ? mem_rdata : '0;
    assign host_rdata = host_own ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: logic/frame_tx.sv
`timescale 1ns/10ps
`default_nettype none

module frame_tx import com_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              fs_tx,
    input  logic [3:0]        tx_btype,
    input  logic [ADDR_W-1:0] tx_ram_init,
    input  logic [ADDR_W-1:0] tx_ram_rlen,
    input  logic              ram_gnt,
    input  logic [BYTE_W-1:0] ram_rdata,
    output logic              fd_tx,
    output logic              ram_req,
    output logic [ADDR_W-1:0] ram_addr,
    output logic [BYTE_W-1:0] tx_byte,
    output logic              tx_stb
);

    localparam logic [2:0] TX_IDLE = 3'd0, TX_HI = 3'd1, TX_LO = 3'd2, TX_DATA = 3'd3;
    localparam logic [2:0] TX_SUM = 3'd4, TX_DONE = 3'd5, TX_HOLD = 3'd6;

    logic [2:0]        state;
    com_hdr_u          hdr;
    logic [ADDR_W-1:0] rd_cnt;    // reads granted
    logic [ADDR_W-1:0] tx_cnt;    // payload bytes sent
    logic              rd_valid;  // ram_rdata holds our byte this cycle
    logic [BYTE_W-1:0] csum;

    // reads start while the low header byte goes out
    assign ram_req  = (state == TX_LO || state == TX_DATA) && (rd_cnt != hdr.f.dlen);
    assign ram_addr = tx_ram_init + rd_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            hdr      <= '0;
            rd_cnt   <= '0;
            tx_cnt   <= '0;
            rd_valid <= 1'b0;
            csum     <= '0;
            tx_byte  <= '0;
            tx_stb   <= 1'b0;
            fd_tx    <= 1'b0;
        end else begin
            tx_stb   <= 1'b0;
            fd_tx    <= 1'b0;
            rd_valid <= ram_req && ram_gnt;
            if (ram_req && ram_gnt) rd_cnt <= rd_cnt + ADDR_W'(1);
            case (state)
                TX_IDLE: if (fs_tx) begin
                    hdr.f.btype <= tx_btype;
                    hdr.f.dlen  <= tx_ram_rlen;
                    rd_cnt      <= '0;
                    tx_cnt      <= '0;
                    state       <= TX_HI;
                end
                TX_HI: begin
                    tx_byte <= hdr.b.hi;
                    tx_stb  <= 1'b1;
                    csum    <= hdr.b.hi;
                    state   <= TX_LO;
                end
                TX_LO: begin
                    tx_byte <= hdr.b.lo;
                    tx_stb  <= 1'b1;
                    csum    <= csum ^ hdr.b.lo;
                    state   <= (hdr.f.dlen == '0) ? TX_SUM : TX_DATA;
                end
                TX_DATA: if (rd_valid) begin
                    tx_byte <= ram_rdata;
                    tx_stb  <= 1'b1;
                    csum    <= csum ^ ram_rdata;
                    tx_cnt  <= tx_cnt + ADDR_W'(1);
                    if (tx_cnt == hdr.f.dlen - ADDR_W'(1)) state <= TX_SUM;
                end
                TX_SUM: begin
                    tx_byte <= csum;
                    tx_stb  <= 1'b1;
                    state   <= TX_DONE;
                end
                TX_DONE: begin
                    fd_tx <= 1'b1;
                    state <= TX_HOLD;
                end
                default: if (!fs_tx) state <= TX_IDLE;  // wait for request to drop
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_rx.sv
`timescale 1ns/10ps
`default_nettype none

module frame_rx import com_pkg::*; #(
    parameter logic [ADDR_W-1:0] RX_BASE = 12'h800
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [BYTE_W-1:0] rx_byte,
    input  logic              rx_stb,
    input  logic              fd_rx,
    input  logic              ram_gnt,
    output logic              fs_rx,
    output logic [3:0]        rx_btype,
    output logic              ram_req,
    output logic              ram_we,
    output logic [ADDR_W-1:0] ram_addr,
    output logic [BYTE_W-1:0] ram_wdata
);

    localparam logic [1:0] RX_HI = 2'd0, RX_LO = 2'd1, RX_BODY = 2'd2;

    logic [1:0]        phase;
    com_hdr_u          hdr;
    logic [ADDR_W-1:0] idx;   // payload bytes seen
    logic [BYTE_W-1:0] csum;
    logic              take;

    assign take   = rx_stb && !fs_rx;  // dropped while a result is pending
    assign ram_we = ram_req;           // this port only writes

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= RX_HI;
            hdr       <= '0;
            idx       <= '0;
            csum      <= '0;
            fs_rx     <= 1'b0;
            rx_btype  <= BAG_INIT;
            ram_req   <= 1'b0;
            ram_addr  <= '0;
            ram_wdata <= '0;
        end else begin
            if (fd_rx) fs_rx <= 1'b0;
            if (ram_gnt) ram_req <= 1'b0;
            if (take) begin
                case (phase)
                    RX_HI: begin
                        hdr.b.hi <= rx_byte;
                        csum     <= rx_byte;
                        phase    <= RX_LO;
                    end
                    RX_LO: begin
                        hdr.b.lo <= rx_byte;
                        csum     <= csum ^ rx_byte;
                        idx      <= '0;
                        phase    <= RX_BODY;
                    end
                    default: begin
                        if (idx == hdr.f.dlen) begin
                            // checksum byte closes the frame
                            fs_rx    <= 1'b1;
                            rx_btype <= (rx_byte == csum) ? hdr.f.btype : BAG_ERROR;
                            phase    <= RX_HI;
                        end else begin
                            ram_req   <= 1'b1;
                            ram_addr  <= RX_BASE + idx;
                            ram_wdata <= rx_byte;
                            csum      <= csum ^ rx_byte;
                            idx       <= idx + ADDR_W'(1);
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/com_cs.sv
`timescale 1ns/10ps
`default_nettype none

module com_cs import com_pkg::*; #(
    parameter logic [7:0] TIMEOUT = 8'd128,
    parameter logic [7:0] NUMOUT  = 8'd16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fs_send,
    input  logic              fd_read,
    input  logic [3:0]        send_btype,
    input  logic [ADDR_W-1:0] send_dlen,
    input  logic [ADDR_W-1:0] ram_addr_init,
    input  logic              fd_tx,
    input  logic              fs_rx,
    input  logic [3:0]        rx_btype,
    output logic              fd_send,
    output logic              fd_txer,
    output logic              fs_read,
    output logic [3:0]        read_btype,
    output logic              fs_tx,
    output logic              fd_rx,
    output logic [3:0]        tx_btype,
    output logic [ADDR_W-1:0] tx_ram_init,
    output logic [ADDR_W-1:0] tx_ram_rlen
);

    localparam logic [7:0] MAIN_IDLE = 8'h00, MAIN_WAIT = 8'h01;
    localparam logic [7:0] SEND_PREP = 8'h20, SEND_DATA = 8'h21;
    localparam logic [7:0] SEND_DONE = 8'h22, SEND_EROR = 8'h23;
    localparam logic [7:0] READ_PREP = 8'h30, READ_DATA = 8'h31, READ_DONE = 8'h32;
    localparam logic [7:0] RANS_WAIT = 8'h40, RANS_TAKE = 8'h41, RANS_DONE = 8'h42;
    localparam logic [7:0] WANS_PREP = 8'h50, WANS_DONE = 8'h51;

    logic [7:0] state, next_state;
    logic [7:0] state_goto;  // where to go once the reply is consumed
    logic [7:0] time_cnt;
    logic [7:0] num_cnt;     // attempts answered so far
    logic       time_up;

    assign time_up = (time_cnt >= TIMEOUT - 8'd1);

    assign fd_send = (state == SEND_DONE);
    assign fd_txer = (state == SEND_EROR);
    assign fs_read = (state == READ_DONE);
    assign fs_tx   = (state == SEND_DATA) || (state == WANS_DONE);
    assign fd_rx   = (state == RANS_DONE) || (state == READ_DATA);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) state <= MAIN_IDLE;
        else     state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_IDLE: next_state = MAIN_WAIT;
            MAIN_WAIT: begin
                if (fs_send)    next_state = SEND_PREP;
                else if (fs_rx) next_state = READ_PREP;
            end
            SEND_PREP: next_state = SEND_DATA;
            SEND_DATA: if (fd_tx) next_state = RANS_WAIT;
            RANS_WAIT: begin
                if (time_up)    next_state = SEND_EROR;  // no reply
                else if (fs_rx) next_state = RANS_TAKE;
            end
            RANS_TAKE: next_state = RANS_DONE;
            RANS_DONE: if (!fs_rx) next_state = state_goto;
            SEND_DONE, SEND_EROR: if (!fs_send) next_state = MAIN_WAIT;
            READ_PREP: next_state = READ_DATA;
            READ_DATA: if (!fs_rx) next_state = WANS_PREP;
            WANS_PREP: next_state = WANS_DONE;
            WANS_DONE: if (fd_tx) next_state = READ_DONE;
            READ_DONE: if (fd_read || time_up) next_state = MAIN_WAIT;
            default:   next_state = MAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_goto  <= MAIN_IDLE;
            read_btype  <= BAG_INIT;
            tx_btype    <= BAG_INIT;
            tx_ram_init <= '0;
            tx_ram_rlen <= '0;
            num_cnt     <= '0;
        end else begin
            case (state)
                MAIN_IDLE, MAIN_WAIT: begin
                    state_goto  <= MAIN_IDLE;
                    read_btype  <= BAG_INIT;
                    tx_btype    <= BAG_INIT;
                    tx_ram_init <= '0;
                    tx_ram_rlen <= '0;  // answer frames carry no payload
                    num_cnt     <= '0;
                end
                SEND_PREP: begin
                    tx_btype    <= send_btype;
                    tx_ram_init <= ram_addr_init;
                    tx_ram_rlen <= send_dlen;
                end
                RANS_TAKE: begin
                    num_cnt <= num_cnt + 8'd1;
                    if (rx_btype == BAG_ACK)
                        state_goto <= SEND_DONE;
                    else if (rx_btype == BAG_NAK && num_cnt < NUMOUT - 8'd1)
                        state_goto <= SEND_DATA;  // resend same frame
                    else
                        state_goto <= SEND_EROR;
                end
                READ_PREP: read_btype <= rx_btype;
                WANS_PREP: tx_btype <= (read_btype == BAG_ERROR) ? BAG_NAK : BAG_ACK;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            time_cnt <= '0;
        else if (state == RANS_WAIT || state == READ_DONE)
            time_cnt <= time_cnt + 8'd1;
        else
            time_cnt <= '0;
    end

endmodule

`default_nettype wire

// File: logic/com_link.sv
`timescale 1ns/10ps
`default_nettype none

module com_link import com_pkg::*; #(
    parameter logic [7:0]        TIMEOUT = 8'd128,
    parameter logic [7:0]        NUMOUT  = 8'd16,
    parameter logic [ADDR_W-1:0] RX_BASE = 12'h800
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fs_send,
    input  logic [3:0]        send_btype,
    input  logic [ADDR_W-1:0] send_dlen,
    input  logic [ADDR_W-1:0] ram_addr_init,
    output logic              fd_send,
    output logic              fd_txer,
    output logic              fs_read,
    output logic [3:0]        read_btype,
    input  logic              fd_read,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [BYTE_W-1:0] host_wdata,
    output logic              host_gnt,
    output logic [BYTE_W-1:0] host_rdata,
    output logic [BYTE_W-1:0] tx_byte,
    output logic              tx_stb,
    input  logic [BYTE_W-1:0] rx_byte,
    input  logic              rx_stb
);

    logic              fs_tx, fd_tx, fs_rx, fd_rx;
    logic [3:0]        tx_btype, rx_btype;
    logic [ADDR_W-1:0] tx_ram_init, tx_ram_rlen;
    logic              rx_req, rx_we, rx_gnt, tx_req, tx_gnt;
    logic [ADDR_W-1:0] rx_addr, tx_addr, mem_addr;
    logic [BYTE_W-1:0] rx_wdata, tx_rdata, mem_wdata, mem_rdata;
    logic              mem_we;

    com_cs #(.TIMEOUT(TIMEOUT), .NUMOUT(NUMOUT)) u_cs (
        .clk(clk), .rst(rst),
        .fs_send(fs_send), .fd_read(fd_read), .send_btype(send_btype),
        .send_dlen(send_dlen), .ram_addr_init(ram_addr_init),
        .fd_tx(fd_tx), .fs_rx(fs_rx), .rx_btype(rx_btype),
        .fd_send(fd_send), .fd_txer(fd_txer), .fs_read(fs_read),
        .read_btype(read_btype), .fs_tx(fs_tx), .fd_rx(fd_rx),
        .tx_btype(tx_btype), .tx_ram_init(tx_ram_init), .tx_ram_rlen(tx_ram_rlen)
    );

    frame_tx u_tx (
        .clk(clk), .rst(rst),
        .fs_tx(fs_tx), .tx_btype(tx_btype), .tx_ram_init(tx_ram_init),
        .tx_ram_rlen(tx_ram_rlen), .ram_gnt(tx_gnt), .ram_rdata(tx_rdata),
        .fd_tx(fd_tx), .ram_req(tx_req), .ram_addr(tx_addr),
        .tx_byte(tx_byte), .tx_stb(tx_stb)
    );

    frame_rx #(.RX_BASE(RX_BASE)) u_rx (
        .clk(clk), .rst(rst),
        .rx_byte(rx_byte), .rx_stb(rx_stb), .fd_rx(fd_rx), .ram_gnt(rx_gnt),
        .fs_rx(fs_rx), .rx_btype(rx_btype), .ram_req(rx_req), .ram_we(rx_we),
        .ram_addr(rx_addr), .ram_wdata(rx_wdata)
    );

    ram_arbiter u_arb (
        .clk(clk), .rst(rst),
        .rx_req(rx_req), .rx_we(rx_we), .rx_addr(rx_addr), .rx_wdata(rx_wdata),
        .tx_req(tx_req), .tx_addr(tx_addr),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .mem_rdata(mem_rdata),
        .rx_gnt(rx_gnt), .tx_gnt(tx_gnt), .tx_rdata(tx_rdata),
        .host_gnt(host_gnt), .host_rdata(host_rdata),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    packet_ram u_ram (
        .clk(clk), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// File: bench/com_link_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module com_link_assertions import com_pkg::*; #(
    parameter logic [7:0]        TIMEOUT = 8'd128,
    parameter logic [7:0]        NUMOUT  = 8'd16,
    parameter logic [ADDR_W-1:0] RX_BASE = 12'h800
) (
    input logic              clk,
    input logic              rst,
    input logic              fs_send,
    input logic [3:0]        send_btype,
    input logic [ADDR_W-1:0] send_dlen,
    input logic [ADDR_W-1:0] ram_addr_init,
    input logic              fd_send,
    input logic              fd_txer,
    input logic              fs_read,
    input logic [3:0]        read_btype,
    input logic              host_req,
    input logic              host_we,
    input logic [ADDR_W-1:0] host_addr,
    input logic [BYTE_W-1:0] host_wdata,
    input logic              host_gnt,
    input logic [BYTE_W-1:0] host_rdata,
    input logic [BYTE_W-1:0] tx_byte,
    input logic              tx_stb,
    input logic [BYTE_W-1:0] rx_byte,
    input logic              rx_stb
);

    logic [BYTE_W-1:0] shadow [0:(1 << ADDR_W)-1];  // expected RAM contents
    logic [ADDR_W-1:0] t_cnt, t_len, r_cnt, r_len, rd_addr;
    logic [BYTE_W-1:0] t_hi, t_x, r_hi, r_x;
    logic [3:0]        r_exp, ans_type;
    logic [7:0]        frames, naks;
    logic [15:0]       since_end, h_wait;
    logic              rd_pend, t_last, r_pay;
    int                fails;

    initial fails = 0;

    assign t_last   = tx_stb && t_cnt >= 12'd2 && (t_cnt - 12'd2) == t_len;
    assign r_pay    = r_cnt >= 12'd2 && (r_cnt - 12'd2) < r_len;
    assign ans_type = (r_exp == BAG_ERROR) ? BAG_NAK : BAG_ACK;

    always_ff @(posedge clk) begin
        if (host_gnt && host_we) shadow[host_addr] <= host_wdata;
        if (rx_stb && r_pay) shadow[RX_BASE + r_cnt - 12'd2] <= rx_byte;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            t_cnt <= '0;
            t_len <= '0;
            t_hi <= '0;
            t_x <= '0;
            r_cnt <= '0;
            r_len <= '0;
            r_hi <= '0;
            r_x <= '0;
            r_exp <= BAG_INIT;
            frames <= '0;
            naks <= '0;
            since_end <= '0;
            h_wait <= '0;
            rd_pend <= 1'b0;
            rd_addr <= '0;
        end else begin
            rd_pend <= host_gnt && !host_we;
            rd_addr <= host_addr;
            h_wait <= (host_req && !host_gnt) ? h_wait + 16'd1 : 16'd0;
            if (since_end != 16'hffff) since_end <= since_end + 16'd1;
            if (!fs_send) begin
                frames <= '0;
                naks <= '0;
            end
            if (tx_stb) begin
                t_cnt <= t_cnt + 12'd1;
                t_x <= (t_cnt == 12'd0) ? tx_byte : t_x ^ tx_byte;
                if (t_cnt == 12'd0) t_hi <= tx_byte;
                if (t_cnt == 12'd1) t_len <= {t_hi[3:0], tx_byte};
                if (t_last) begin
                    t_cnt <= '0;
                    since_end <= '0;
                    if (fs_send) frames <= frames + 8'd1;
                end
            end
            if (rx_stb) begin
                r_cnt <= r_cnt + 12'd1;
                r_x <= (r_cnt == 12'd0) ? rx_byte : r_x ^ rx_byte;
                if (r_cnt == 12'd0) r_hi <= rx_byte;
                if (r_cnt == 12'd1) r_len <= {r_hi[3:0], rx_byte};
                if (r_cnt >= 12'd2 && !r_pay) begin
                    // checksum byte from the peer
                    r_cnt <= '0;
                    r_exp <= (rx_byte == r_x) ? r_hi[7:4] : BAG_ERROR;
                    if (rx_byte == r_x && r_hi[7:4] == BAG_NAK && fs_send)
                        naks <= naks + 8'd1;
                end
            end
        end
    end

    a_hi: assert property (@(posedge clk) disable iff (rst)
        tx_stb && t_cnt == 12'd0 |->
            tx_byte == (fs_send ? {send_btype, send_dlen[11:8]} : {ans_type, 4'h0}))
        else begin fails++; $error("t=%0t header byte hi wrong", $time); end

    a_lo: assert property (@(posedge clk) disable iff (rst)
        tx_stb && t_cnt == 12'd1 |-> tx_byte == (fs_send ? send_dlen[7:0] : 8'h00))
        else begin fails++; $error("t=%0t header byte lo wrong", $time); end

    a_pay: assert property (@(posedge clk) disable iff (rst)
        tx_stb && t_cnt >= 12'd2 && (t_cnt - 12'd2) < t_len |->
            tx_byte == shadow[ram_addr_init + t_cnt - 12'd2])
        else begin fails++; $error("t=%0t payload byte differs from RAM", $time); end

    a_sum: assert property (@(posedge clk) disable iff (rst) t_last |-> tx_byte == t_x)
        else begin fails++; $error("t=%0t transmitted checksum wrong", $time); end

    a_type: assert property (@(posedge clk) disable iff (rst)
        $rose(fs_read) |-> read_btype == r_exp)
        else begin fails++; $error("t=%0t read_btype %0h wrong", $time, read_btype); end

    a_hrd: assert property (@(posedge clk) disable iff (rst)
        rd_pend |-> host_rdata == shadow[rd_addr])
        else begin fails++; $error("t=%0t host read data wrong", $time); end

    a_hgnt: assert property (@(posedge clk) disable iff (rst) host_req |-> h_wait < 16'd40)
        else begin fails++; $error("t=%0t host request starved", $time); end

    a_tmo: assert property (@(posedge clk) disable iff (rst)
        $rose(fd_txer) |-> since_end <= {8'h00, TIMEOUT} + 16'd4)
        else begin fails++; $error("t=%0t fd_txer late after frame end", $time); end

    a_tries: assert property (@(posedge clk) disable iff (rst)
        $rose(fd_txer) |-> frames <= NUMOUT && (naks < NUMOUT || frames == NUMOUT))
        else begin fails++; $error("t=%0t wrong attempt count %0d", $time, frames); end

endmodule

bind com_link com_link_assertions #(
    .TIMEOUT(TIMEOUT), .NUMOUT(NUMOUT), .RX_BASE(RX_BASE)
) u_chk (.*);

`default_nettype wire

// File: bench/com_link_tb.sv
`timescale 1ns/10ps
`default_nettype none

module com_link_tb import com_pkg::*; ();

    localparam logic [7:0]  TIMEOUT_TB = 8'd32;
    localparam logic [7:0]  NUMOUT_TB  = 8'd3;
    localparam logic [11:0] RX_BASE_TB = 12'h800;
    localparam logic [11:0] TX_BASE    = 12'h100;
    localparam logic [11:0] LEN        = 12'd16;
    // NUMOUT frames with replies
    localparam int SEND_LIMIT = int'(NUMOUT_TB) * (int'(TIMEOUT_TB) + 2 * int'(LEN) + 20);
    localparam int WD_CYCLES  = 7 * (SEND_LIMIT + 40 * int'(LEN) + 200);
    localparam int ACK_MODE = 0, NAK_MODE = 1, SILENT = 2;

    logic        clk, rst, fs_send, fd_read, host_req, host_we, rx_stb;
    logic [3:0]  send_btype, read_btype;
    logic [11:0] send_dlen, ram_addr_init, host_addr;
    logic [7:0]  host_wdata, host_rdata, tx_byte, rx_byte;
    logic        fd_send, fd_txer, fs_read, host_gnt, tx_stb;
    logic [31:0] seed = 32'h46b9_10aa;
    int          peer_mode, naks_left, frames_seen, tb_fails, mark, tests;
    bit          send_over;

    com_link #(.TIMEOUT(TIMEOUT_TB), .NUMOUT(NUMOUT_TB), .RX_BASE(RX_BASE_TB)) UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic peer_frame(input logic [3:0] t, input logic [11:0] n, input bit bad);
        com_hdr_u    h;
        logic [7:0]  x;
        logic [11:0] i;
        h.f.btype = t;
        h.f.dlen = n;
        @(posedge clk);
        rx_byte <= h.b.hi;
        rx_stb <= 1'b1;
        x = h.b.hi;
        @(posedge clk);
        rx_byte <= h.b.lo;
        x = x ^ h.b.lo;
        for (i = 12'd0; i < n; i++) begin
            seed = xorshift(seed);
            @(posedge clk);
            rx_byte <= seed[7:0];
            x = x ^ seed[7:0];
        end
        @(posedge clk);
        rx_byte <= bad ? ~x : x;  // corrupt on request
        @(posedge clk);
        rx_stb <= 1'b0;
    endtask

    task automatic host_access(input bit we, input logic [11:0] a, input logic [7:0] d);
        int n;
        n = 0;
        @(posedge clk);
        host_req <= 1'b1;
        host_we <= we;
        host_addr <= a;
        host_wdata <= d;
        do begin
            @(negedge clk);
            n++;
        end while (!host_gnt && n < 100);
        if (!host_gnt) begin
            $display("host request at %0t was never granted", $time);
            tb_fails++;
        end
        @(posedge clk);
        host_req <= 1'b0;
    endtask

    task automatic user_send(input string name, input bit want_ack);
        int n;
        n = 0;
        @(posedge clk);
        fs_send <= 1'b1;
        send_btype <= BAG_DATA1;
        send_dlen <= LEN;
        ram_addr_init <= TX_BASE;
        do begin
            @(negedge clk);
            n++;
        end while (!(fd_send || fd_txer) && n < SEND_LIMIT);
        if (!(fd_send || fd_txer)) begin
            $display("%s: send request never finished", name);
            tb_fails++;
        end else if (fd_send != want_ack || fd_txer == want_ack) begin
            $display("ERROR %0t: %s ended with fd_send=%0b fd_txer=%0b",
                $time, name, fd_send, fd_txer);
            tb_fails++;
        end
        @(posedge clk);
        fs_send <= 1'b0;
        repeat (3) @(posedge clk);
        send_over = 1'b1;
    endtask

    task automatic peer_receive(input bit bad);
        int n;
        n = 0;
        peer_frame(BAG_DATA0, bad ? 12'd4 : LEN, bad);
        do begin
            @(negedge clk);
            n++;
        end while (!fs_read && n < 100);
        if (!fs_read) begin
            $display("fs_read never rose after the peer frame");
            tb_fails++;
        end
        @(posedge clk);
        fd_read <= 1'b1;
        @(posedge clk);
        fd_read <= 1'b0;
    endtask

    task automatic report(input string name);
        int now;
        now = tb_fails + UUT.u_chk.fails;
        tests++;
        $display("test %s %s (%0d new failures)", name, (now == mark) ? "ok" : "bad",
            now - mark);
        mark = now;
    endtask

    // behavioral peer that replies only to frames of a send
    initial begin
        logic [11:0] cnt, len;
        logic [7:0]  hi;
        cnt = '0;
        len = '0;
        hi = '0;
        forever begin
            @(negedge clk);
            if (tx_stb) begin
                if (cnt == 12'd0) hi = tx_byte;
                if (cnt == 12'd1) len = {hi[3:0], tx_byte};
                if (cnt >= 12'd2 && cnt - 12'd2 == len) begin
                    cnt = '0;
                    frames_seen++;
                    if (fs_send && peer_mode != SILENT) begin
                        if (naks_left > 0 || peer_mode == NAK_MODE) begin
                            naks_left--;
                            peer_frame(BAG_NAK, 12'd0, 1'b0);
                        end else begin
                            peer_frame(BAG_ACK, 12'd0, 1'b0);
                        end
                    end
                end else begin
                    cnt++;
                end
            end
        end
    end

    initial begin
        #(WD_CYCLES * 8);
        $display("watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [11:0] i;
        clk = 1'b0;
        rst = 1'b1;
        {fs_send, fd_read, host_req, host_we, rx_stb} = '0;
        {send_btype, send_dlen, ram_addr_init, host_addr, host_wdata, rx_byte} = '0;
        {peer_mode, naks_left, frames_seen, tb_fails, mark, tests} = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (i = 12'd0; i < LEN; i++) begin
            seed = xorshift(seed);
            host_access(1'b1, TX_BASE + i, seed[7:0]);
        end
        peer_mode = ACK_MODE;
        user_send("send_ack", 1'b1);
        report("send_ack");
        naks_left = 1;
        user_send("retry", 1'b1);
        report("retry");
        peer_mode = SILENT;
        user_send("silent", 1'b0);
        report("silent");
        peer_mode = NAK_MODE;
        frames_seen = 0;
        user_send("nak_all", 1'b0);
        if (frames_seen != int'(NUMOUT_TB)) begin
            $display("ERROR %0t: nak_all sent %0d frames", $time, frames_seen);
            tb_fails++;
        end
        report("nak_all");
        peer_receive(1'b0);
        for (i = 12'd0; i < LEN; i++) host_access(1'b0, RX_BASE_TB + i, 8'h00);
        report("good_rx");
        peer_receive(1'b1);
        report("bad_rx");
        peer_mode = ACK_MODE;
        send_over = 1'b0;
        fork
            user_send("contention", 1'b1);
            begin
                i = 12'd0;
                while (!send_over) begin
                    host_access(1'b0, TX_BASE + (i % LEN), 8'h00);
                    i++;
                end
            end
        join
        report("contention");
        $display("%0d tests, %0d bench failures, %0d assertion failures",
            tests, tb_fails, UUT.u_chk.fails);
        if (tb_fails == 0 && UUT.u_chk.fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/com_pkg.sv
logic/packet_ram.sv
logic/ram_arbiter.sv
logic/frame_tx.sv
logic/frame_rx.sv
logic/com_cs.sv
logic/com_link.sv
bench/com_link_assertions.sv
bench/com_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator; exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module com_link_tb -Mdir obj_dir -f filelist.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vcom_link_tb +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
